// File: trace_arch_pkg.sv
// Architectural constants for the trace unit
// Word and register index widths, CSR bit offsets and CSR index codes

package trace_arch_pkg;

    //------------------------------------------------------------------
    // Data path
    //------------------------------------------------------------------
    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;   // Covers both RVE and RVI register files
    localparam int EC_W       = 4;   // mcause exception code

    //------------------------------------------------------------------
    // CSR field positions
    //------------------------------------------------------------------
    localparam int MSTATUS_MIE_OFFSET  = 3;
    localparam int MSTATUS_MPIE_OFFSET = 7;
    localparam int MSTATUS_MPP_OFFSET  = 11;  // Two bits wide

    // Shared by mie and mip
    localparam int MIE_MSIE_OFFSET = 3;
    localparam int MIE_MTIE_OFFSET = 7;
    localparam int MIE_MEIE_OFFSET = 11;

    // Machine mode only core
    localparam logic [1:0] MSTATUS_MPP_M = 2'b11;

    //------------------------------------------------------------------
    // Traced CSR set
    //------------------------------------------------------------------
    localparam int NUM_CSR   = 7;
    localparam int CSR_IDX_W = 3;

    // Lower code wins when several words change together
    typedef enum logic [CSR_IDX_W-1:0] {
        CSR_MSTATUS = 3'd0,
        CSR_MTVEC   = 3'd1,
        CSR_MIE     = 3'd2,
        CSR_MIP     = 3'd3,
        CSR_MEPC    = 3'd4,
        CSR_MCAUSE  = 3'd5,
        CSR_MTVAL   = 3'd6
    } csr_idx_e;

endpackage : trace_arch_pkg

// File: trace_rec_pkg.sv
// Trace record format
// Record kinds and the record word with its retire and CSR views

package trace_rec_pkg;

    import trace_arch_pkg::*;

    localparam int STAMP_W   = 16;
    localparam int CSR_PAD_W = 34;  // Fills the CSR view up to the retire view

    typedef enum logic {
        REC_RETIRE = 1'b0,
        REC_CSR    = 1'b1
    } rec_kind_e;

    // 1 + 16 + 32 + 5 + 32 + 32 = 118 bits
    typedef struct packed {
        rec_kind_e              kind;
        logic [STAMP_W-1:0]     stamp;
        logic [XLEN-1:0]        pc;
        logic [REG_ADDR_W-1:0]  rd;
        logic [XLEN-1:0]        new_val;
        logic [XLEN-1:0]        old_val;
    } retire_view_s;

    // 1 + 16 + 3 + 32 + 32 + 34 = 118 bits
    typedef struct packed {
        rec_kind_e              kind;
        logic [STAMP_W-1:0]     stamp;
        csr_idx_e               idx;
        logic [XLEN-1:0]        new_val;
        logic [XLEN-1:0]        old_val;
        logic [CSR_PAD_W-1:0]   pad;
    } csr_view_s;

    // Kind bit is the MSB in both views
    typedef union packed {
        retire_view_s   ret;
        csr_view_s      csr;
    } trace_rec_u;

endpackage : trace_rec_pkg

// File: shadow_regfile.sv
// Shadow integer register file
// One-cycle staging of retire events with new and previous rd value

`timescale 1ns/1ps

module shadow_regfile
    import trace_arch_pkg::*;
#(
    parameter int NUM_REGS = 32
) (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    mprf_wr_en,
    input  logic [REG_ADDR_W-1:0]   mprf_wr_addr,
    input  logic [XLEN-1:0]         mprf_wr_data,
    input  logic                    update_pc_en,
    input  logic [XLEN-1:0]         update_pc,
    output logic                    evt_valid,
    output logic [XLEN-1:0]         evt_pc,
    output logic [REG_ADDR_W-1:0]   evt_rd,
    output logic [XLEN-1:0]         evt_new,
    output logic [XLEN-1:0]         evt_old
);

    logic [XLEN-1:0] regs [1:NUM_REGS-1];  // x0 is not stored
    logic            wr_live;

    assign wr_live = mprf_wr_en && (mprf_wr_addr != '0);

    // Shadow copy starts from the architectural reset value
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wr_live) begin
            regs[mprf_wr_addr] <= mprf_wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            evt_valid <= 1'b0;
        end else begin
            evt_valid <= update_pc_en;
        end
    end

    // Old value is read on the same edge the new one is written
    always_ff @(posedge clk) begin
        if (update_pc_en) begin
            evt_pc <= update_pc;
            if (wr_live) begin
                evt_rd  <= mprf_wr_addr;
                evt_new <= mprf_wr_data;
                evt_old <= regs[mprf_wr_addr];
            end else begin
                evt_rd  <= '0;      // No write or x0
                evt_new <= '0;
                evt_old <= '0;
            end
        end
    end

    a_wr_addr_range : assert property (@(posedge clk) disable iff (!rst_n)
        mprf_wr_en |-> (mprf_wr_addr < NUM_REGS));

endmodule : shadow_regfile

// File: csr_snapshot.sv
// CSR word assembly from single fields
// Logged copy of each word, change mask and selected word readout

`timescale 1ns/1ps

module csr_snapshot
    import trace_arch_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    mstatus_mie,
    input  logic                    mstatus_mpie,
    input  logic [XLEN-1:6]         mtvec_base,
    input  logic                    mtvec_mode,
    input  logic                    mie_meie,
    input  logic                    mie_mtie,
    input  logic                    mie_msie,
    input  logic                    mip_meip,
    input  logic                    mip_mtip,
    input  logic                    mip_msip,
    input  logic [XLEN-1:1]         mepc,
    input  logic                    mcause_int,
    input  logic [EC_W-1:0]         mcause_ec,
    input  logic [XLEN-1:0]         mtval,
    input  csr_idx_e                csr_sel,
    input  logic                    csr_take,
    output logic [NUM_CSR-1:0]      csr_changed,
    output logic [XLEN-1:0]         sel_new,
    output logic [XLEN-1:0]         sel_old
);

    logic [XLEN-1:0] csr_word [NUM_CSR];   // Live value
    logic [XLEN-1:0] csr_log  [NUM_CSR];   // Last value put in a record

    //------------------------------------------------------------------
    // Word assembly
    //------------------------------------------------------------------
    always_comb begin
        csr_word[CSR_MSTATUS] = '0;
        csr_word[CSR_MSTATUS][MSTATUS_MIE_OFFSET]       = mstatus_mie;
        csr_word[CSR_MSTATUS][MSTATUS_MPIE_OFFSET]      = mstatus_mpie;
        csr_word[CSR_MSTATUS][MSTATUS_MPP_OFFSET +: 2]  = MSTATUS_MPP_M;

        csr_word[CSR_MTVEC] = {mtvec_base, 5'd0, mtvec_mode};

        csr_word[CSR_MIE] = '0;
        csr_word[CSR_MIE][MIE_MSIE_OFFSET] = mie_msie;
        csr_word[CSR_MIE][MIE_MTIE_OFFSET] = mie_mtie;
        csr_word[CSR_MIE][MIE_MEIE_OFFSET] = mie_meie;

        // Same bit layout as mie
        csr_word[CSR_MIP] = '0;
        csr_word[CSR_MIP][MIE_MSIE_OFFSET] = mip_msip;
        csr_word[CSR_MIP][MIE_MTIE_OFFSET] = mip_mtip;
        csr_word[CSR_MIP][MIE_MEIE_OFFSET] = mip_meip;

        csr_word[CSR_MEPC]   = {mepc, 1'b0};
        csr_word[CSR_MCAUSE] = {mcause_int, {(XLEN-1-EC_W){1'b0}}, mcause_ec};
        csr_word[CSR_MTVAL]  = mtval;
    end

    //------------------------------------------------------------------
    // Logged copies and change detection
    //------------------------------------------------------------------
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_CSR; i++) begin
                csr_log[i] <= '0;
            end
        end else if (csr_take) begin
            csr_log[csr_sel] <= csr_word[csr_sel];
        end
    end

    always_comb begin
        for (int i = 0; i < NUM_CSR; i++) begin
            csr_changed[i] = (csr_word[i] != csr_log[i]);
        end
    end

    assign sel_new = csr_word[csr_sel];
    assign sel_old = csr_log[csr_sel];

    // Controller must only log a word that really moved
    a_take_changed : assert property (@(posedge clk) disable iff (!rst_n)
        csr_take |-> csr_changed[csr_sel]);

endmodule : csr_snapshot

// File: trace_fifo.sv
// Record queue, first word fall through
// Circular buffer with the head on the valid/ready output

`timescale 1ns/1ps

module trace_fifo
    import trace_rec_pkg::*;
#(
    parameter int FIFO_DEPTH = 4
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        push,
    input  trace_rec_u  push_rec,
    input  logic        trace_ready,
    output logic        full,
    output logic        trace_valid,
    output trace_rec_u  trace_rec
);

    localparam int PTR_W = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;

    trace_rec_u         mem [FIFO_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;
    logic [PTR_W:0]     count;
    logic               pop;

    assign pop         = trace_valid && trace_ready;
    assign trace_valid = (count != '0);
    assign full        = (count == (PTR_W+1)'(FIFO_DEPTH));
    assign trace_rec   = mem[rd_ptr];   // Head shown directly

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= push_rec;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == PTR_W'(FIFO_DEPTH-1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == PTR_W'(FIFO_DEPTH-1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    a_no_push_full : assert property (@(posedge clk) disable iff (!rst_n)
        push |-> !full);

endmodule : trace_fifo

// File: trace_ctrl.sv
// Trace controller
// Stamp counter, retire/CSR arbitration, record building, overflow flag

`timescale 1ns/1ps

module trace_ctrl
    import trace_arch_pkg::*;
    import trace_rec_pkg::*;
(
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    evt_valid,
    input  logic [XLEN-1:0]         evt_pc,
    input  logic [REG_ADDR_W-1:0]   evt_rd,
    input  logic [XLEN-1:0]         evt_new,
    input  logic [XLEN-1:0]         evt_old,
    input  logic [NUM_CSR-1:0]      csr_changed,
    input  logic [XLEN-1:0]         sel_new,
    input  logic [XLEN-1:0]         sel_old,
    input  logic                    full,
    output csr_idx_e                csr_sel,
    output logic                    csr_take,
    output logic                    push,
    output trace_rec_u              push_rec,
    output logic                    overflow
);

    logic [STAMP_W-1:0] stamp_cnt;
    logic               trace_en;   // Low for the reset cycles

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            stamp_cnt <= '0;
            trace_en  <= 1'b0;
            overflow  <= 1'b0;
        end else begin
            stamp_cnt <= stamp_cnt + 1'b1;
            trace_en  <= 1'b1;
            if (evt_valid && full) begin
                overflow <= 1'b1;   // Sticky, retire record lost
            end
        end
    end

    //------------------------------------------------------------------
    // Arbitration
    //------------------------------------------------------------------
    always_comb begin
        csr_sel = CSR_MSTATUS;
        for (int i = NUM_CSR - 1; i >= 0; i--) begin
            if (csr_changed[i]) begin
                csr_sel = csr_idx_e'(i);
            end
        end
    end

    // Retire events never wait, CSR words only go when the slot is free
    assign csr_take = trace_en && !evt_valid && !full && (|csr_changed);
    assign push     = (evt_valid && !full) || csr_take;

    //------------------------------------------------------------------
    // Record building
    //------------------------------------------------------------------
    always_comb begin
        push_rec = '0;
        if (evt_valid) begin
            push_rec.ret.kind    = REC_RETIRE;
            push_rec.ret.stamp   = stamp_cnt - 1'b1;  // Edge the retire was sampled
            push_rec.ret.pc      = evt_pc;
            push_rec.ret.rd      = evt_rd;
            push_rec.ret.new_val = evt_new;
            push_rec.ret.old_val = evt_old;
        end else begin
            push_rec.csr.kind    = REC_CSR;
            push_rec.csr.stamp   = stamp_cnt;
            push_rec.csr.idx     = csr_sel;
            push_rec.csr.new_val = sel_new;
            push_rec.csr.old_val = sel_old;
        end
    end

endmodule : trace_ctrl

// File: trace_top.sv
// Trace unit top level
// Shadow register file, CSR snapshot, controller and record queue

`timescale 1ns/1ps

module trace_top
    import trace_arch_pkg::*;
    import trace_rec_pkg::*;
#(
    parameter int NUM_REGS   = 32,   // 16 for an RVE core
    parameter int FIFO_DEPTH = 4
) (
    input  logic                    clk,
    input  logic                    rst_n,
    // Register file write port
    input  logic                    mprf_wr_en,
    input  logic [REG_ADDR_W-1:0]   mprf_wr_addr,
    input  logic [XLEN-1:0]         mprf_wr_data,
    // Retire
    input  logic                    update_pc_en,
    input  logic [XLEN-1:0]         update_pc,
    // CSR fields
    input  logic                    mstatus_mie,
    input  logic                    mstatus_mpie,
    input  logic [XLEN-1:6]         mtvec_base,
    input  logic                    mtvec_mode,
    input  logic                    mie_meie,
    input  logic                    mie_mtie,
    input  logic                    mie_msie,
    input  logic                    mip_meip,
    input  logic                    mip_mtip,
    input  logic                    mip_msip,
    input  logic [XLEN-1:1]         mepc,
    input  logic                    mcause_int,
    input  logic [EC_W-1:0]         mcause_ec,
    input  logic [XLEN-1:0]         mtval,
    // Record stream
    output logic                    trace_valid,
    input  logic                    trace_ready,
    output trace_rec_u              trace_rec,
    output logic                    overflow
);

    logic                   evt_valid;
    logic [XLEN-1:0]        evt_pc;
    logic [REG_ADDR_W-1:0]  evt_rd;
    logic [XLEN-1:0]        evt_new;
    logic [XLEN-1:0]        evt_old;
    logic [NUM_CSR-1:0]     csr_changed;
    logic [XLEN-1:0]        sel_new;
    logic [XLEN-1:0]        sel_old;
    csr_idx_e               csr_sel;
    logic                   csr_take;
    logic                   push;
    trace_rec_u             push_rec;
    logic                   full;

    shadow_regfile #(.NUM_REGS(NUM_REGS)) shadow_regfile_i (
        .clk(clk), .rst_n(rst_n),
        .mprf_wr_en(mprf_wr_en), .mprf_wr_addr(mprf_wr_addr), .mprf_wr_data(mprf_wr_data),
        .update_pc_en(update_pc_en), .update_pc(update_pc),
        .evt_valid(evt_valid), .evt_pc(evt_pc), .evt_rd(evt_rd),
        .evt_new(evt_new), .evt_old(evt_old)
    );

    csr_snapshot csr_snapshot_i (
        .clk(clk), .rst_n(rst_n),
        .mstatus_mie(mstatus_mie), .mstatus_mpie(mstatus_mpie),
        .mtvec_base(mtvec_base), .mtvec_mode(mtvec_mode),
        .mie_meie(mie_meie), .mie_mtie(mie_mtie), .mie_msie(mie_msie),
        .mip_meip(mip_meip), .mip_mtip(mip_mtip), .mip_msip(mip_msip),
        .mepc(mepc), .mcause_int(mcause_int), .mcause_ec(mcause_ec), .mtval(mtval),
        .csr_sel(csr_sel), .csr_take(csr_take),
        .csr_changed(csr_changed), .sel_new(sel_new), .sel_old(sel_old)
    );

    trace_ctrl trace_ctrl_i (
        .clk(clk), .rst_n(rst_n),
        .evt_valid(evt_valid), .evt_pc(evt_pc), .evt_rd(evt_rd),
        .evt_new(evt_new), .evt_old(evt_old),
        .csr_changed(csr_changed), .sel_new(sel_new), .sel_old(sel_old),
        .full(full), .csr_sel(csr_sel), .csr_take(csr_take),
        .push(push), .push_rec(push_rec), .overflow(overflow)
    );

    trace_fifo #(.FIFO_DEPTH(FIFO_DEPTH)) trace_fifo_i (
        .clk(clk), .rst_n(rst_n),
        .push(push), .push_rec(push_rec), .trace_ready(trace_ready),
        .full(full), .trace_valid(trace_valid), .trace_rec(trace_rec)
    );

endmodule : trace_top

// File: tb_trace.sv
// Testbench for the trace unit
// Replays the commands of trace_input.txt and checks every record on the output stream

`timescale 1ns/1ps

module tb_trace
    import trace_arch_pkg::*;
    import trace_rec_pkg::*;
();

    localparam int    CLK_PERIOD   = 100;
    localparam int    DRIVE_DLY    = 1;
    localparam int    RESET_CYCLES = 10;
    localparam int    DRAIN_CYCLES = 8;
    localparam string STIM_FILE    = "trace_input.txt";

    logic                   clk;
    logic                   rst_n;
    logic                   mprf_wr_en;
    logic [REG_ADDR_W-1:0]  mprf_wr_addr;
    logic [XLEN-1:0]        mprf_wr_data;
    logic                   update_pc_en;
    logic [XLEN-1:0]        update_pc;
    logic                   mstatus_mie;
    logic                   mstatus_mpie;
    logic [XLEN-1:6]        mtvec_base;
    logic                   mtvec_mode;
    logic                   mie_meie;
    logic                   mie_mtie;
    logic                   mie_msie;
    logic                   mip_meip;
    logic                   mip_mtip;
    logic                   mip_msip;
    logic [XLEN-1:1]        mepc;
    logic                   mcause_int;
    logic [EC_W-1:0]        mcause_ec;
    logic [XLEN-1:0]        mtval;
    logic                   trace_valid;
    logic                   trace_ready;
    trace_rec_u             trace_rec;
    logic                   overflow;

    // Expected records in output order
    rec_kind_e      exp_kind  [$];
    logic [31:0]    exp_idx   [$];
    logic [31:0]    exp_new   [$];
    logic [31:0]    exp_old   [$];
    int             exp_stamp [$];  // -1 means not checked
    logic [31:0]    retire_pc [int];    // Retire PC by the stamp of its sampling edge

    string  cmd_q [$];
    int     stim_cycles = 0;
    int     cycle_cnt   = 0;
    int     cycle_limit = 200;

    trace_top #(
        .NUM_REGS(32),
        .FIFO_DEPTH(4)
    ) dut_i (
        .clk(clk), .rst_n(rst_n),
        .mprf_wr_en(mprf_wr_en), .mprf_wr_addr(mprf_wr_addr), .mprf_wr_data(mprf_wr_data),
        .update_pc_en(update_pc_en), .update_pc(update_pc),
        .mstatus_mie(mstatus_mie), .mstatus_mpie(mstatus_mpie),
        .mtvec_base(mtvec_base), .mtvec_mode(mtvec_mode),
        .mie_meie(mie_meie), .mie_mtie(mie_mtie), .mie_msie(mie_msie),
        .mip_meip(mip_meip), .mip_mtip(mip_mtip), .mip_msip(mip_msip),
        .mepc(mepc), .mcause_int(mcause_int), .mcause_ec(mcause_ec), .mtval(mtval),
        .trace_valid(trace_valid), .trace_ready(trace_ready),
        .trace_rec(trace_rec), .overflow(overflow)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    //------------------------------------------------------------------
    // Helpers
    //------------------------------------------------------------------
    task automatic fail_run(input string msg);
        $display("%s", msg);
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
        if (got !== exp) begin
            fail_run($sformatf("Error: time %0t, signal %s is %h, expected %h",
                               $time, name, got, exp));
        end
    endtask

    // Splits the file into commands and expected records
    task automatic load_stimulus();
        int             fd;
        string          line;
        string          tag;
        string          kind_s;
        string          stamp_s;
        int             num;
        int             level;
        int             st;
        logic [31:0]    nv;
        logic [31:0]    ov;

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            fail_run("Cannot open the stimulus file trace_input.txt");
        end
        while (!$feof(fd)) begin
            line = "";
            void'($fgets(line, fd));
            if ($sscanf(line, "%s", tag) != 1 || tag.substr(0, 0) == "#") begin
                continue;
            end
            if (tag == "E") begin
                stamp_s = "-";
                st      = -1;
                void'($sscanf(line, "%s %s %d %h %h %s", tag, kind_s, num, nv, ov, stamp_s));
                if (stamp_s != "-") begin
                    void'($sscanf(stamp_s, "%d", st));
                end
                exp_kind.push_back((kind_s == "C") ? REC_CSR : REC_RETIRE);
                exp_idx.push_back(32'(num));
                exp_new.push_back(nv);
                exp_old.push_back(ov);
                exp_stamp.push_back(st);
            end else begin
                if (tag == "W") begin
                    stim_cycles += 1;
                end else if (tag == "R") begin
                    void'($sscanf(line, "%s %d %d", tag, level, num));
                    stim_cycles += num;
                end
                cmd_q.push_back(line);
            end
        end
        $fclose(fd);
        cycle_limit = 2 * stim_cycles + 200;
    endtask

    task automatic drive_field(input string field, input logic [31:0] val);
        if (field == "mstatus_mie")       mstatus_mie  = val[0];
        else if (field == "mstatus_mpie") mstatus_mpie = val[0];
        else if (field == "mtvec_base")   mtvec_base   = val[XLEN-7:0];
        else if (field == "mtvec_mode")   mtvec_mode   = val[0];
        else if (field == "mie_meie")     mie_meie     = val[0];
        else if (field == "mie_mtie")     mie_mtie     = val[0];
        else if (field == "mie_msie")     mie_msie     = val[0];
        else if (field == "mip_meip")     mip_meip     = val[0];
        else if (field == "mip_mtip")     mip_mtip     = val[0];
        else if (field == "mip_msip")     mip_msip     = val[0];
        else if (field == "mepc")         mepc         = val[XLEN-2:0];
        else if (field == "mcause_int")   mcause_int   = val[0];
        else if (field == "mcause_ec")    mcause_ec    = val[EC_W-1:0];
        else if (field == "mtval")        mtval        = val;
        else fail_run({"Unknown CSR field in the stimulus file: ", field});
    endtask

    task automatic run_command(input string line);
        string          tag;
        string          field;
        int             a;
        int             b;
        logic [31:0]    data;
        logic [31:0]    pc;

        void'($sscanf(line, "%s", tag));
        if (tag == "W") begin
            void'($sscanf(line, "%s %d %h %d %h", tag, a, data, b, pc));
            mprf_wr_en   = 1'b1;
            mprf_wr_addr = a[REG_ADDR_W-1:0];
            mprf_wr_data = data;
            update_pc_en = b[0];
            update_pc    = pc;
            if (b[0]) begin
                retire_pc[cycle_cnt - RESET_CYCLES] = pc;   // Stamp of the coming edge
            end
            @(posedge clk);
            #DRIVE_DLY;
            mprf_wr_en   = 1'b0;
            update_pc_en = 1'b0;
        end else if (tag == "C") begin
            void'($sscanf(line, "%s %s %h", tag, field, data));
            drive_field(field, data);   // Takes no time
        end else if (tag == "R") begin
            void'($sscanf(line, "%s %d %d", tag, a, b));
            trace_ready = a[0];
            repeat (b) @(posedge clk);
            #DRIVE_DLY;
        end else if (tag == "O") begin
            void'($sscanf(line, "%s %d", tag, a));
            check_value("overflow", 32'(overflow), 32'(a));
        end else begin
            fail_run({"Unknown command in the stimulus file: ", line});
        end
    endtask

    task automatic compare_record();
        rec_kind_e      kind;
        logic [31:0]    idx;
        logic [31:0]    nv;
        logic [31:0]    ov;
        int             st;

        kind = exp_kind.pop_front();
        idx  = exp_idx.pop_front();
        nv   = exp_new.pop_front();
        ov   = exp_old.pop_front();
        st   = exp_stamp.pop_front();
        check_value("trace_rec.kind", 32'(trace_rec.ret.kind), 32'(kind));
        if (kind == REC_RETIRE) begin
            check_value("trace_rec.ret.rd", 32'(trace_rec.ret.rd), idx);
            check_value("trace_rec.ret.new_val", trace_rec.ret.new_val, nv);
            check_value("trace_rec.ret.old_val", trace_rec.ret.old_val, ov);
            if (st >= 0) begin
                check_value("trace_rec.ret.stamp", 32'(trace_rec.ret.stamp), 32'(st));
                if (retire_pc.exists(st)) begin
                    check_value("trace_rec.ret.pc", trace_rec.ret.pc, retire_pc[st]);
                end else begin
                    fail_run("An expected retire record has no retire driven at its stamp");
                end
            end
        end else begin
            check_value("trace_rec.csr.idx", 32'(trace_rec.csr.idx), idx);
            check_value("trace_rec.csr.new_val", trace_rec.csr.new_val, nv);
            check_value("trace_rec.csr.old_val", trace_rec.csr.old_val, ov);
            check_value("trace_rec.csr.pad[31:0]", trace_rec.csr.pad[31:0], 32'd0);
            check_value("trace_rec.csr.pad[33:32]",
                        32'(trace_rec.csr.pad[CSR_PAD_W-1:32]), 32'd0);
            if (st >= 0) begin
                check_value("trace_rec.csr.stamp", 32'(trace_rec.csr.stamp), 32'(st));
            end
        end
    endtask

    //------------------------------------------------------------------
    // Output monitor and cycle limit
    //------------------------------------------------------------------
    // Mid cycle, so valid and ready are settled for the next edge
    always @(negedge clk) begin
        if (!rst_n && cycle_cnt > 0) begin
            check_value("trace_valid", 32'(trace_valid), 32'd0);
            check_value("overflow", 32'(overflow), 32'd0);
        end else if (rst_n && trace_valid && trace_ready) begin
            if (exp_kind.size() == 0) begin
                fail_run("A record came out that the stimulus file does not expect");
            end else begin
                compare_record();
            end
        end
    end

    always @(posedge clk) begin
        cycle_cnt = cycle_cnt + 1;
        if (cycle_cnt > cycle_limit) begin
            fail_run("Timeout, the expected records did not all come out");
        end
    end

    initial begin
        rst_n        = 1'b0;
        mprf_wr_en   = 1'b0;
        mprf_wr_addr = '0;
        mprf_wr_data = '0;
        update_pc_en = 1'b0;
        update_pc    = '0;
        mstatus_mie  = 1'b0;
        mstatus_mpie = 1'b0;
        mtvec_base   = '0;
        mtvec_mode   = 1'b0;
        mie_meie     = 1'b0;
        mie_mtie     = 1'b0;
        mie_msie     = 1'b0;
        mip_meip     = 1'b0;
        mip_mtip     = 1'b0;
        mip_msip     = 1'b0;
        mepc         = '0;
        mcause_int   = 1'b0;
        mcause_ec    = '0;
        mtval        = '0;
        trace_ready  = 1'b1;

        load_stimulus();
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;

        foreach (cmd_q[i]) begin
            run_command(cmd_q[i]);
        end

        trace_ready = 1'b1;
        while (exp_kind.size() != 0) begin
            @(posedge clk);
        end
        repeat (DRAIN_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        if (!trace_valid) begin
            $display("TEST RESULT: PASS");
            $finish;
        end else begin
            fail_run("A record is left in the queue after all expected records");
        end
    end

endmodule : tb_trace

// File: trace_input.txt
# Commands: W rd data(hex) retire pc(hex) | C field value(hex, right aligned) | R ready cycles | O overflow
# Expected: E kind(R/C) rd_or_csr_index new(hex) old(hex) stamp(decimal, - for none), in output order
#
# Reset state, mstatus comes out first with MPP set
R 1 4
E C 0 00001800 00000000 1
# Retire records with the previous value of rd
W 5 0000abcd 1 00000100
E R 5 0000abcd 00000000 4
W 5 12345678 1 00000104
E R 5 12345678 0000abcd 5
# Write to x0 with retire, then a write without retire
W 0 deadbeef 1 00000108
E R 0 00000000 00000000 6
W 7 00000077 0 00000000
W 7 00000099 1 0000010c
E R 7 00000099 00000077 8
R 1 4
O 0
# Single CSR changes, mip first and then mepc
C mip_mtip 1
R 1 3
E C 3 00000080 00000000 13
C mepc 00000080
R 1 3
E C 4 00000100 00000000 16
# mtvec and mcause change in the same cycle
C mtvec_base 00000001
C mtvec_mode 1
C mcause_int 1
C mcause_ec b
R 1 4
E C 1 00000041 00000000 19
E C 5 8000000b 00000000 20
# Six retires with the output stalled, mepc changes twice meanwhile
R 0 1
W 1 00000011 1 00000200
W 2 00000022 1 00000204
C mepc 00000100
W 3 00000033 1 00000208
W 4 00000044 1 0000020c
W 5 00000055 1 00000210
W 6 00000066 1 00000214
C mepc 00000180
R 0 4
O 1
R 1 10
E R 1 00000011 00000000 24
E R 2 00000022 00000000 25
E R 3 00000033 00000000 26
E R 4 00000044 00000000 27
E C 4 00000300 00000100 35
O 1

// File: sim.f
trace_arch_pkg.sv
trace_rec_pkg.sv
shadow_regfile.sv
csr_snapshot.sv
trace_fifo.sv
trace_ctrl.sv
trace_top.sv
tb_trace.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build and run the trace unit testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sim.f --top-module tb_trace -o tb_trace
./obj_dir/tb_trace | tee sim.log

if grep -q "TEST RESULT: PASS" sim.log; then
    echo "Simulation passed"
    exit 0
else
    echo "Simulation failed"
    exit 1
fi
